// ==== all.f ====
+incdir+verilog
verilog/link_pkg.sv
verilog/link_if.sv
verilog/link_buf.sv
verilog/frame_tx.sv
verilog/frame_rx.sv
verilog/link_ctrl.sv
verilog/link_top.sv
verif/link_tb.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and decide on the log contents
verilator --binary --timing -Wno-fatal --top-module link_tb -f all.f -o link_sim \
    > build.log 2>&1 &&
    ./obj_dir/link_sim > sim.log 2>&1 ||
    { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^Simulation passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/link_tb.sv ====
`include "link_consts.svh"

module link_tb import link_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_FRAME   = 3 + 15;
    localparam int N_EXCH      = 25;
    localparam int CYCLE_LIMIT = 2 * N_EXCH * (`LINK_RETRY_MAX + 1) *
                                 (MAX_FRAME + `LINK_TIMEOUT);

    // peer reply codes, one per transmitted frame
    localparam int R_ACK = 0;
    localparam int R_NAK = 1;
    localparam int R_BAD = 2;
    localparam int R_STL = 3;

    logic       clk = 1'b0;
    logic       rst;
    logic       send_req;
    bag_type_e  send_btype;
    logic [3:0] send_len;
    logic [7:0] send_addr;
    logic       send_done;
    logic       send_ok;
    logic       read_valid;
    logic       read_ack;
    bag_type_e  read_btype;
    logic [3:0] read_len;
    logic [7:0] read_addr;
    logic       host_tx_wr_en;
    logic [7:0] host_tx_addr;
    logic [7:0] host_tx_wdata;
    logic [7:0] host_rx_addr;
    logic [7:0] host_rx_rdata;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready = 1'b1;
    logic [7:0] rx_data;
    logic       rx_valid;

    integer seed       = 32'h208f;
    integer stall_seed = 32'h208f + 1;

    // reference model state
    logic [7:0] tx_mem [0:255];
    logic [7:0] rx_mem [0:255];
    logic       seq_m = 1'b0;
    logic [7:0] bad_m = 8'h00;
    logic       stall_en = 1'b0;

    int err_cnt = 0;
    int chk_cnt = 0;
    int cycles  = 0;

    // byte collector state
    logic [7:0] byte_q [$];
    int         col_cnt = 0;
    int         col_need = 3;
    logic [7:0] col_hi;
    link_hdr_u  col_hdr;
    int         frames_ready = 0;
    int         frames_used = 0;
    logic [7:0] frm [0:MAX_FRAME-1];
    int         frm_len;
    logic [7:0] rx_frm [0:MAX_FRAME-1];
    int         reply_q [$];

    link_top DUT (
        .clk           (clk),
        .rst           (rst),
        .send_req      (send_req),
        .send_btype    (send_btype),
        .send_len      (send_len),
        .send_addr     (send_addr),
        .send_done     (send_done),
        .send_ok       (send_ok),
        .read_valid    (read_valid),
        .read_ack      (read_ack),
        .read_btype    (read_btype),
        .read_len      (read_len),
        .read_addr     (read_addr),
        .host_tx_wr_en (host_tx_wr_en),
        .host_tx_addr  (host_tx_addr),
        .host_tx_wdata (host_tx_wdata),
        .host_rx_addr  (host_rx_addr),
        .host_rx_rdata (host_rx_rdata),
        .tx_data       (tx_data),
        .tx_valid      (tx_valid),
        .tx_ready      (tx_ready),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        tx_ready = stall_en ? (($random(stall_seed) & 3) != 0) : 1'b1;
    end

    // split the outgoing byte stream into frames
    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            byte_q.push_back(tx_data);
            if (col_cnt == 0)
                col_hi = tx_data;
            if (col_cnt == 1) begin
                col_hdr  = {col_hi, tx_data};
                col_need = is_ctrl_type(col_hdr.data_hdr.btype) ? 3 :
                           3 + int'(col_hdr.data_hdr.len);
            end
            col_cnt = col_cnt + 1;
            if (col_cnt >= 3 && col_cnt == col_need) begin
                frames_ready = frames_ready + 1;
                col_cnt      = 0;
            end
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        $display("Simulation failed");
        $finish;
    end

    task automatic chk_type(input string name, input bag_type_e exp, input bag_type_e act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic chk_hdr(input string name, input link_hdr_u exp, input link_hdr_u act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic chk_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic chk_flag(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (exp !== act) begin
            err_cnt++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    function automatic bag_type_e pick_data_type();
        case ($random(seed) & 7)
            0:       return DATA0;
            1:       return DATA1;
            2:       return DIDX;
            3:       return DPARAM;
            4:       return DDIDX;
            5:       return DLINK;
            6:       return DTYPE;
            default: return DTEMP;
        endcase
    endfunction

    // pops the next complete frame into frm
    task automatic wait_frame();
        link_hdr_u h;
        while (frames_ready == frames_used) begin
            @(posedge clk);
            #1;
        end
        frm[0] = byte_q.pop_front();
        frm[1] = byte_q.pop_front();
        h = {frm[0], frm[1]};
        frm_len = is_ctrl_type(h.data_hdr.btype) ? 3 : 3 + int'(h.data_hdr.len);
        for (int i = 2; i < frm_len; i++)
            frm[i] = byte_q.pop_front();
        frames_used++;
    endtask

    task automatic check_frame_len(input string name, input int exp);
        chk_cnt++;
        if (frm_len != exp) begin
            err_cnt++;
            $display("[ERROR] %s: expected %0d bytes, actual %0d", name, exp, frm_len);
        end
    endtask

    task automatic check_data_frame(input string name, input link_hdr_u exp);
        logic [7:0] cs;
        logic [7:0] a;
        check_frame_len(name, 3 + int'(exp.data_hdr.len));
        chk_hdr(name, exp, {frm[0], frm[1]});
        cs = exp[15:8] ^ exp[7:0];
        for (int i = 0; i < int'(exp.data_hdr.len); i++) begin
            a = exp.data_hdr.addr + 8'(i);
            chk_byte(name, tx_mem[a], frm[2 + i]);
            cs = cs ^ tx_mem[a];
        end
        chk_byte(name, cs, frm[frm_len - 1]);
    endtask

    task automatic drive_rx_bytes(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            rx_valid = 1'b1;
            rx_data  = rx_frm[i];
        end
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic drive_ctrl(input bag_type_e t, input logic corrupt);
        rx_frm[0] = {t, 4'h0};
        rx_frm[1] = 8'h00;
        rx_frm[2] = rx_frm[0] ^ rx_frm[1];
        if (corrupt)
            rx_frm[2] = rx_frm[2] ^ (8'($random(seed)) | 8'h01);
        drive_rx_bytes(3);
    endtask

    task automatic answer(input int code);
        case (code)
            R_ACK: drive_ctrl(ACK, 1'b0);
            R_NAK: drive_ctrl(NAK, 1'b0);
            R_BAD: drive_ctrl(ACK, 1'b1);
            default: begin
                // the ack lands later than one full wait after the frame
                repeat (`LINK_TIMEOUT / 2 + ($random(seed) & 15)) @(posedge clk);
                drive_ctrl(STL, 1'b0);
                repeat (`LINK_TIMEOUT / 2 + ($random(seed) & 31)) @(posedge clk);
                drive_ctrl(ACK, 1'b0);
            end
        endcase
    endtask

    task automatic script(input int n_nak, input int last);
        reply_q.delete();
        repeat (n_nak) reply_q.push_back(R_NAK);
        if (last >= 0)
            reply_q.push_back(last);
    endtask

    task automatic write_payload(input logic [7:0] addr, input int len);
        logic [7:0] a;
        logic [7:0] d;
        for (int i = 0; i < len; i++) begin
            a = addr + 8'(i);
            d = 8'($random(seed));
            tx_mem[a] = d;
            @(posedge clk);
            #1;
            host_tx_wr_en = 1'b1;
            host_tx_addr  = a;
            host_tx_wdata = d;
        end
        @(posedge clk);
        #1;
        host_tx_wr_en = 1'b0;
    endtask

    task automatic run_send(input string name, input bag_type_e req);
        link_hdr_u exp_hdr;
        int        len;
        int        n_exp;
        logic      ok_exp;
        len  = $random(seed) & 15;
        exp_hdr.data_hdr.btype = (req == DATA0 && seq_m) ? DATA1 : req;
        exp_hdr.data_hdr.len   = 4'(len);
        exp_hdr.data_hdr.addr  = 8'($random(seed));
        write_payload(exp_hdr.data_hdr.addr, len);
        // frames and outcome follow from the reply script
        n_exp  = 0;
        ok_exp = 1'b0;
        for (int t = 0; t < `LINK_RETRY_MAX; t++) begin
            n_exp++;
            if (t >= reply_q.size())
                break;
            if (reply_q[t] == R_ACK || reply_q[t] == R_STL) begin
                ok_exp = 1'b1;
                break;
            end
        end
        send_req   = 1'b1;
        send_btype = req;
        send_len   = 4'(len);
        send_addr  = exp_hdr.data_hdr.addr;
        fork
            begin
                for (int i = 0; i < n_exp; i++) begin
                    wait_frame();
                    check_data_frame(name, exp_hdr);
                    if (i < reply_q.size())
                        answer(reply_q[i]);
                end
            end
            begin
                while (!send_done) begin
                    @(posedge clk);
                    #1;
                end
            end
        join
        chk_flag(name, ok_exp, send_ok);
        send_req = 1'b0;
        @(posedge clk);
        #1;
        if (send_done) begin
            err_cnt++;
            $display("%s: send_done stayed high after send_req fell", name);
        end
        if (frames_ready != frames_used || col_cnt != 0) begin
            err_cnt++;
            $display("%s: the DUT sent more frames than the replies allow", name);
        end
        if (req == DATA0)
            seq_m = ~seq_m;
    endtask

    task automatic run_incoming(input string name, input logic corrupt);
        link_hdr_u  hdr;
        link_hdr_u  reply_exp;
        logic [7:0] cs;
        logic [7:0] a;
        int         len;
        len = $random(seed) & 15;
        hdr.data_hdr.btype = pick_data_type();
        hdr.data_hdr.len   = 4'(len);
        hdr.data_hdr.addr  = 8'($random(seed));
        rx_frm[0] = hdr[15:8];
        rx_frm[1] = hdr[7:0];
        cs = rx_frm[0] ^ rx_frm[1];
        for (int i = 0; i < len; i++) begin
            a = hdr.data_hdr.addr + 8'(i);
            rx_frm[2 + i] = 8'($random(seed));
            rx_mem[a] = rx_frm[2 + i];
            cs = cs ^ rx_frm[2 + i];
        end
        // a flipped checksum leaves the framing intact
        rx_frm[2 + len] = corrupt ? cs ^ (8'($random(seed)) | 8'h01) : cs;
        drive_rx_bytes(len + 3);
        bad_m = corrupt ? bad_m + 8'd1 : 8'd0;
        reply_exp.ctrl_hdr.btype   = corrupt ? NAK : ACK;
        reply_exp.ctrl_hdr.rsvd    = 4'h0;
        reply_exp.ctrl_hdr.bad_cnt = bad_m;
        wait_frame();
        check_frame_len(name, 3);
        chk_hdr(name, reply_exp, {frm[0], frm[1]});
        chk_byte(name, reply_exp[15:8] ^ reply_exp[7:0], frm[2]);
        if (corrupt) begin
            repeat (4) begin
                @(posedge clk);
                #1;
                if (read_valid) begin
                    err_cnt++;
                    $display("%s: read_valid rose for a corrupt frame", name);
                end
            end
        end else begin
            while (!read_valid) begin
                @(posedge clk);
                #1;
            end
            chk_type(name, hdr.data_hdr.btype, read_btype);
            chk_hdr(name, hdr, {read_btype, read_len, read_addr});
            for (int i = 0; i < len; i++) begin
                a = hdr.data_hdr.addr + 8'(i);
                host_rx_addr = a;
                @(posedge clk);
                #1;
                chk_byte(name, rx_mem[a], host_rx_rdata);
            end
            chk_flag(name, 1'b1, read_valid);
            read_ack = 1'b1;
            @(posedge clk);
            #1;
            read_ack = 1'b0;
            chk_flag(name, 1'b0, read_valid);
        end
    endtask

    initial begin
        int k;
        rst           = 1'b1;
        send_req      = 1'b0;
        send_btype    = INIT;
        send_len      = 4'h0;
        send_addr     = 8'h00;
        read_ack      = 1'b0;
        host_tx_wr_en = 1'b0;
        host_tx_addr  = 8'h00;
        host_tx_wdata = 8'h00;
        host_rx_addr  = 8'h00;
        rx_data       = 8'h00;
        rx_valid      = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        repeat (6) begin
            script(0, R_ACK);
            run_send("clean", pick_data_type());
        end
        // sequence bit alternation
        repeat (3) begin
            script(0, R_ACK);
            run_send("data0_seq", DATA0);
        end

        k = 1 + (($random(seed) & 32'h7fff) % 14);
        script(k, R_ACK);
        run_send("retry_nak", pick_data_type());
        script(`LINK_RETRY_MAX, -1);
        run_send("retry_limit", DATA0);
        script(0, R_BAD);
        reply_q.push_back(R_ACK);
        run_send("retry_bad_ack", pick_data_type());

        script(0, -1);
        run_send("timeout", pick_data_type());
        script(0, R_STL);
        run_send("stall_reply", pick_data_type());

        run_incoming("rx_good", 1'b0);
        run_incoming("rx_good", 1'b0);
        run_incoming("rx_corrupt", 1'b1);
        run_incoming("rx_corrupt", 1'b1);
        run_incoming("rx_recover", 1'b0);

        stall_en = 1'b1;
        repeat (4) begin
            script(0, R_ACK);
            run_send("backpressure", pick_data_type());
        end
        script(2, R_ACK);
        run_send("backpressure_retry", DATA0);
        script(0, R_STL);
        run_send("backpressure_stl", DATA0);

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog/frame_rx.sv ====
`include "link_consts.svh"

module frame_rx import link_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    rx_frame_if.deframer            fr,
    output logic                    buf_wr_en,
    output logic [`LINK_ADDR_W-1:0] buf_wr_addr,
    output logic [7:0]              buf_wr_data,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid
);

    localparam int PAD_W = `LINK_ADDR_W - `LINK_LEN_W;

    localparam logic [1:0] S_HDR_H = 2'd0;
    localparam logic [1:0] S_HDR_L = 2'd1;
    localparam logic [1:0] S_PAY   = 2'd2;
    localparam logic [1:0] S_CSUM  = 2'd3;

    logic [1:0]             state;
    link_hdr_u              hdr_r;
    link_hdr_u              hdr_in;
    logic [`LINK_LEN_W-1:0] idx;
    logic [`LINK_LEN_W-1:0] pay_len;
    logic [7:0]             csum;
    logic                   done_r;
    logic                   bad_r;

    // full header as seen while the low byte arrives
    assign hdr_in  = {hdr_r[15:8], rx_data};
    assign pay_len = is_ctrl_type(hdr_in.data_hdr.btype) ? '0 : hdr_in.data_hdr.len;

    assign buf_wr_en   = rx_valid && (state == S_PAY);
    assign buf_wr_addr = hdr_r.data_hdr.addr + {{PAD_W{1'b0}}, idx};
    assign buf_wr_data = rx_data;

    assign fr.frame_done = done_r;
    assign fr.hdr        = hdr_r;
    assign fr.bad        = bad_r;
    assign fr.hdr_type   = bad_r ? ERROR : hdr_r.data_hdr.btype;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_HDR_H;
            idx    <= '0;
            done_r <= 1'b0;
            bad_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (rx_valid) begin
                case (state)
                    S_HDR_H:
                        state <= S_HDR_L;
                    S_HDR_L: begin
                        idx   <= '0;
                        state <= (pay_len == '0) ? S_CSUM : S_PAY;
                    end
                    S_PAY: begin
                        idx <= idx + 1'b1;
                        if (idx == hdr_r.data_hdr.len - 1'b1)
                            state <= S_CSUM;
                    end
                    default: begin
                        done_r <= 1'b1;
                        bad_r  <= (rx_data != csum);
                        state  <= S_HDR_H;
                    end
                endcase
            end
        end
    end

    // running xor restarts with the first header byte
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            if (state == S_HDR_H) begin
                hdr_r[15:8] <= rx_data;
                csum        <= rx_data;
            end else if (state == S_HDR_L) begin
                hdr_r[7:0] <= rx_data;
                csum       <= csum ^ rx_data;
            end else if (state == S_PAY) begin
                csum <= csum ^ rx_data;
            end
        end
    end

endmodule

// ==== verilog/frame_tx.sv ====
`include "link_consts.svh"

module frame_tx import link_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    tx_frame_if.framer              fr,
    output logic [`LINK_ADDR_W-1:0] buf_addr,
    input  logic [7:0]              buf_data,
    output logic [7:0]              tx_data,
    output logic                    tx_valid,
    input  logic                    tx_ready
);

    localparam int PAD_W = `LINK_ADDR_W - `LINK_LEN_W;

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_FILL  = 3'd1;
    localparam logic [2:0] S_HDR_H = 3'd2;
    localparam logic [2:0] S_HDR_L = 3'd3;
    localparam logic [2:0] S_PAY   = 3'd4;
    localparam logic [2:0] S_CSUM  = 3'd5;
    localparam logic [2:0] S_DONE  = 3'd6;

    logic [2:0]             state;
    logic [`LINK_LEN_W-1:0] idx;
    logic [`LINK_LEN_W-1:0] idx_nxt;
    logic [`LINK_LEN_W-1:0] pay_len;
    logic [7:0]             csum;
    logic                   xfer;

    assign xfer    = tx_valid && tx_ready;
    assign pay_len = is_ctrl_type(fr.hdr.data_hdr.btype) ? '0 : fr.hdr.data_hdr.len;

    always_comb begin
        idx_nxt = idx;
        if (fr.start)
            idx_nxt = '0;
        else if (state == S_PAY && xfer)
            idx_nxt = idx + 1'b1;
    end

    // address runs one byte ahead so the buffer output is ready without a bubble
    assign buf_addr = fr.hdr.data_hdr.addr + {{PAD_W{1'b0}}, idx_nxt};

    always_comb begin
        case (state)
            S_HDR_H: tx_data = fr.hdr[15:8];
            S_HDR_L: tx_data = fr.hdr[7:0];
            S_PAY:   tx_data = buf_data;
            default: tx_data = csum;
        endcase
    end

    assign tx_valid = (state == S_HDR_H) || (state == S_HDR_L) ||
                      (state == S_PAY) || (state == S_CSUM);
    assign fr.done  = (state == S_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= S_IDLE;
            idx   <= '0;
        end else begin
            idx <= idx_nxt;
            case (state)
                S_IDLE: begin
                    if (fr.start)
                        state <= S_FILL;
                end
                S_FILL:
                    state <= S_HDR_H;
                S_HDR_H: begin
                    if (xfer)
                        state <= S_HDR_L;
                end
                S_HDR_L: begin
                    if (xfer)
                        state <= (pay_len == '0) ? S_CSUM : S_PAY;
                end
                S_PAY: begin
                    if (xfer && idx == pay_len - 1'b1)
                        state <= S_CSUM;
                end
                S_CSUM: begin
                    if (xfer)
                        state <= S_DONE;
                end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fr.start)
            csum <= '0;
        else if (xfer && state != S_CSUM)
            csum <= csum ^ tx_data;
    end

endmodule

// ==== verilog/link_buf.sv ====
`include "link_consts.svh"

module link_buf (
    input  logic                    clk,
    input  logic                    wr_en,
    input  logic [`LINK_ADDR_W-1:0] wr_addr,
    input  logic [7:0]              wr_data,
    input  logic [`LINK_ADDR_W-1:0] rd_addr,
    output logic [7:0]              rd_data
);

    logic [7:0] mem [0:(1 << `LINK_ADDR_W) - 1];

    // read returns old data on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/link_consts.svh ====
`ifndef LINK_CONSTS_SVH
`define LINK_CONSTS_SVH

// cycles to wait for a reply once a frame has left
`define LINK_TIMEOUT 128

// transmissions of one packet before the send fails
`define LINK_RETRY_MAX 16

`define LINK_ADDR_W 8
`define LINK_LEN_W 4

`endif

// ==== verilog/link_ctrl.sv ====
`include "link_consts.svh"

module link_ctrl import link_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    tx_frame_if.ctrl                tx,
    rx_frame_if.ctrl                rx,
    input  logic                    send_req,
    input  bag_type_e               send_btype,
    input  logic [`LINK_LEN_W-1:0]  send_len,
    input  logic [`LINK_ADDR_W-1:0] send_addr,
    output logic                    send_done,
    output logic                    send_ok,
    output logic                    read_valid,
    input  logic                    read_ack,
    output bag_type_e               read_btype,
    output logic [`LINK_LEN_W-1:0]  read_len,
    output logic [`LINK_ADDR_W-1:0] read_addr
);

    localparam int TMO_W = $clog2(`LINK_TIMEOUT);
    localparam int TRY_W = $clog2(`LINK_RETRY_MAX + 1);
    localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(`LINK_TIMEOUT - 1);
    localparam logic [TRY_W-1:0] TRY_LAST = TRY_W'(`LINK_RETRY_MAX);

    localparam logic [2:0] S_IDLE   = 3'd0;
    localparam logic [2:0] S_START  = 3'd1;
    localparam logic [2:0] S_BUSY   = 3'd2;
    localparam logic [2:0] S_WAIT   = 3'd3;
    localparam logic [2:0] S_DONE   = 3'd4;
    localparam logic [2:0] S_RSTART = 3'd5;
    localparam logic [2:0] S_RBUSY  = 3'd6;
    localparam logic [2:0] S_NOTIFY = 3'd7;

    logic [2:0]              state;
    logic [TMO_W-1:0]        timer;
    logic [TRY_W-1:0]        tries;
    logic                    seq;
    logic                    req_data0;
    logic                    rx_bad_l;
    logic [`LINK_ADDR_W-1:0] bad_cnt;
    logic [`LINK_ADDR_W-1:0] bad_cnt_nxt;
    link_hdr_u               tx_hdr;
    bag_type_e               send_type;
    logic                    rx_take;

    assign send_type   = (send_btype == DATA0 && seq) ? DATA1 : send_btype;
    // data frames are only answered while nothing else is going on
    assign rx_take     = (state == S_IDLE) && !send_req && rx.frame_done &&
                         !is_ctrl_type(rx.hdr_type);
    assign bad_cnt_nxt = rx.bad ? bad_cnt + 1'b1 : '0;

    assign tx.start   = (state == S_START) || (state == S_RSTART);
    assign tx.hdr     = tx_hdr;
    assign send_done  = (state == S_DONE);
    assign read_valid = (state == S_NOTIFY);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= S_IDLE;
            timer     <= '0;
            tries     <= '0;
            seq       <= 1'b0;
            req_data0 <= 1'b0;
            rx_bad_l  <= 1'b0;
            bad_cnt   <= '0;
            send_ok   <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (send_req) begin
                        req_data0 <= (send_btype == DATA0);
                        tries     <= '0;
                        send_ok   <= 1'b0;
                        state     <= S_START;
                    end else if (rx_take) begin
                        rx_bad_l <= rx.bad;
                        bad_cnt  <= bad_cnt_nxt;
                        state    <= S_RSTART;
                    end
                end
                S_START: begin
                    tries <= tries + 1'b1;
                    state <= S_BUSY;
                end
                S_BUSY: begin
                    timer <= '0;
                    if (tx.done)
                        state <= S_WAIT;
                end
                S_WAIT: begin
                    timer <= timer + 1'b1;
                    if (rx.frame_done && rx.hdr_type == ACK) begin
                        send_ok <= 1'b1;
                        state   <= S_DONE;
                    end else if (rx.frame_done && rx.hdr_type == STL) begin
                        timer <= '0;
                    end else if (rx.frame_done && (rx.hdr_type == NAK || rx.hdr_type == ERROR)) begin
                        state <= (tries == TRY_LAST) ? S_DONE : S_START;
                    end else if (timer == TMO_LAST) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (!send_req) begin
                        if (req_data0)
                            seq <= ~seq;
                        state <= S_IDLE;
                    end
                end
                S_RSTART:
                    state <= S_RBUSY;
                S_RBUSY: begin
                    if (tx.done)
                        state <= rx_bad_l ? S_IDLE : S_NOTIFY;
                end
                default: begin
                    if (read_ack)
                        state <= S_IDLE;
                end
            endcase
        end
    end

    // outgoing header and host read fields
    always_ff @(posedge clk) begin
        if (state == S_IDLE && send_req) begin
            tx_hdr.data_hdr.btype <= send_type;
            tx_hdr.data_hdr.len   <= send_len;
            tx_hdr.data_hdr.addr  <= send_addr;
        end else if (rx_take) begin
            tx_hdr.ctrl_hdr.btype   <= rx.bad ? NAK : ACK;
            tx_hdr.ctrl_hdr.rsvd    <= '0;
            tx_hdr.ctrl_hdr.bad_cnt <= bad_cnt_nxt;
            read_btype <= rx.hdr.data_hdr.btype;
            read_len   <= rx.hdr.data_hdr.len;
            read_addr  <= rx.hdr.data_hdr.addr;
        end
    end

endmodule

// ==== verilog/link_if.sv ====
// controller hands a header to the framer and waits for done
interface tx_frame_if import link_pkg::*; ();

    logic      start;
    link_hdr_u hdr;
    logic      done;

    modport ctrl (
        output start,
        output hdr,
        input  done
    );

    modport framer (
        input  start,
        input  hdr,
        output done
    );

endinterface

// one pulse per received frame, header valid during the pulse
interface rx_frame_if import link_pkg::*; ();

    logic      frame_done;
    link_hdr_u hdr;
    logic      bad;
    bag_type_e hdr_type;

    modport deframer (output frame_done, output hdr, output bad, output hdr_type);

    modport ctrl (input frame_done, input hdr, input bad, input hdr_type);

endinterface

// ==== verilog/link_pkg.sv ====
`include "link_consts.svh"

package link_pkg;

    typedef enum logic [3:0] {
        INIT   = 4'd0,
        ACK    = 4'd1,
        NAK    = 4'd2,
        STL    = 4'd3,
        DIDX   = 4'd5,
        DPARAM = 4'd6,
        DDIDX  = 4'd7,
        DLINK  = 4'd8,
        DTYPE  = 4'd9,
        DTEMP  = 4'd10,
        DATA0  = 4'd13,
        DATA1  = 4'd14,
        ERROR  = 4'd15
    } bag_type_e;

    // first word of every frame, sent high byte first
    typedef union packed {
        struct packed {
            bag_type_e              btype;
            logic [`LINK_LEN_W-1:0]  len;
            logic [`LINK_ADDR_W-1:0] addr;
        } data_hdr;
        struct packed {
            bag_type_e              btype;
            logic [`LINK_LEN_W-1:0]  rsvd;
            logic [`LINK_ADDR_W-1:0] bad_cnt;
        } ctrl_hdr;
    } link_hdr_u;

    // ack, nak and stl frames carry no payload
    function automatic logic is_ctrl_type(bag_type_e t);
        return (t == ACK) || (t == NAK) || (t == STL);
    endfunction

endpackage

// ==== verilog/link_top.sv ====
`include "link_consts.svh"

module link_top import link_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    send_req,
    input  bag_type_e               send_btype,
    input  logic [`LINK_LEN_W-1:0]  send_len,
    input  logic [`LINK_ADDR_W-1:0] send_addr,
    output logic                    send_done,
    output logic                    send_ok,
    output logic                    read_valid,
    input  logic                    read_ack,
    output bag_type_e               read_btype,
    output logic [`LINK_LEN_W-1:0]  read_len,
    output logic [`LINK_ADDR_W-1:0] read_addr,
    input  logic                    host_tx_wr_en,
    input  logic [`LINK_ADDR_W-1:0] host_tx_addr,
    input  logic [7:0]              host_tx_wdata,
    input  logic [`LINK_ADDR_W-1:0] host_rx_addr,
    output logic [7:0]              host_rx_rdata,
    output logic [7:0]              tx_data,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid
);

    logic [`LINK_ADDR_W-1:0] tx_buf_addr;
    logic [7:0]              tx_buf_data;
    logic                    rx_buf_wr_en;
    logic [`LINK_ADDR_W-1:0] rx_buf_wr_addr;
    logic [7:0]              rx_buf_wr_data;

    tx_frame_if txf ();
    rx_frame_if rxf ();

    // host fills this one, framer drains it
    link_buf u_tx_buf (
        .clk     (clk),
        .wr_en   (host_tx_wr_en),
        .wr_addr (host_tx_addr),
        .wr_data (host_tx_wdata),
        .rd_addr (tx_buf_addr),
        .rd_data (tx_buf_data)
    );

    link_buf u_rx_buf (
        .clk     (clk),
        .wr_en   (rx_buf_wr_en),
        .wr_addr (rx_buf_wr_addr),
        .wr_data (rx_buf_wr_data),
        .rd_addr (host_rx_addr),
        .rd_data (host_rx_rdata)
    );

    frame_tx u_frame_tx (
        .clk      (clk),
        .rst      (rst),
        .fr       (txf),
        .buf_addr (tx_buf_addr),
        .buf_data (tx_buf_data),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    frame_rx u_frame_rx (
        .clk         (clk),
        .rst         (rst),
        .fr          (rxf),
        .buf_wr_en   (rx_buf_wr_en),
        .buf_wr_addr (rx_buf_wr_addr),
        .buf_wr_data (rx_buf_wr_data),
        .rx_data     (rx_data),
        .rx_valid    (rx_valid)
    );

    link_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .tx         (txf),
        .rx         (rxf),
        .send_req   (send_req),
        .send_btype (send_btype),
        .send_len   (send_len),
        .send_addr  (send_addr),
        .send_done  (send_done),
        .send_ok    (send_ok),
        .read_valid (read_valid),
        .read_ack   (read_ack),
        .read_btype (read_btype),
        .read_len   (read_len),
        .read_addr  (read_addr)
    );

endmodule
